/* Bender.yml */
package:
  name: core_pipeline

sources:
  - src/cpu_pkg.sv
  - src/fetch_unit.sv
  - src/pipe_reg.sv
  - src/reg_file_bypass.sv
  - src/decode.sv
  - src/execute.sv
  - src/core_top.sv
  - target: test
    files:
      - tests/core_tb.sv

/* flist.f */
src/cpu_pkg.sv
src/fetch_unit.sv
src/pipe_reg.sv
src/reg_file_bypass.sv
src/decode.sv
src/execute.sv
src/core_top.sv
tests/core_tb.sv

/* src/core_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three stage core, fetch decode execute
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module core_top import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	output logic [xlen-1:0] imem_addr,
	input  logic [xlen-1:0] imem_data,
	output wb_t             wb,
	output mem_req_t        mem_req,
	output logic            illegal
);

	fetch_pkt_t fetch_pkt_d;
	fetch_pkt_t fetch_pkt_q;
	exec_pkt_t  exec_pkt_d;
	exec_pkt_t  exec_pkt_q;
	redirect_t  redirect;

	fetch_unit fetch_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.redirect  (redirect),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.fetch_pkt (fetch_pkt_d)
	);

	// fetch to decode
	pipe_reg #(.payload_t(fetch_pkt_t)) if_id (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (redirect.valid),
		.d     (fetch_pkt_d),
		.q     (fetch_pkt_q)
	);

	// wb loops back into the register file
	decode decode_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.fetch_pkt (fetch_pkt_q),
		.wb        (wb),
		.exec_pkt  (exec_pkt_d)
	);

	// decode to execute
	pipe_reg #(.payload_t(exec_pkt_t)) id_ex (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (redirect.valid),
		.d     (exec_pkt_d),
		.q     (exec_pkt_q)
	);

	execute execute_inst (
		.exec_pkt (exec_pkt_q),
		.wb       (wb),
		.mem_req  (mem_req),
		.redirect (redirect),
		.illegal  (illegal)
	);

endmodule

/* src/cpu_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcodes, field positions and stage structs
// imported by every pipeline stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

	// widths
	localparam int xlen      = 32;
	localparam int num_regs  = 32;
	localparam int reg_sel_w = 5;
	localparam int op_w      = 5;
	// shift amount taken from the low bits of rs2
	localparam int shamt_w   = 5;

	// instruction field positions
	localparam int op_msb    = 31;
	localparam int op_lsb    = 27;
	localparam int rd_msb    = 26;
	localparam int rd_lsb    = 22;
	localparam int rs1_msb   = 21;
	localparam int rs1_lsb   = 17;
	localparam int rs2_msb   = 16;
	localparam int rs2_lsb   = 12;
	// immediates are sign extended from these msbs down to bit 0
	localparam int imm_s_msb = 16;
	localparam int imm_l_msb = 21;

	// opcode encodings, rin sits at the top code
	typedef enum logic [op_w-1:0] {
		op_add  = 5'd0,
		op_addi = 5'd1,
		op_sub  = 5'd2,
		op_subi = 5'd3,
		op_and  = 5'd4,
		op_or   = 5'd5,
		op_xor  = 5'd6,
		op_neg  = 5'd7,
		op_sll  = 5'd8,
		op_slr  = 5'd9,
		op_sar  = 5'd10,
		op_ld   = 5'd11,
		op_ldi  = 5'd12,
		op_st   = 5'd13,
		op_sti  = 5'd14,
		op_nop  = 5'd15,
		op_beq  = 5'd16,
		op_bne  = 5'd17,
		op_bon  = 5'd18,
		op_bnn  = 5'd19,
		op_j    = 5'd20,
		op_jr   = 5'd21,
		op_jal  = 5'd22,
		op_rin  = 5'd31
	} opcode_e;

	// second alu operand
	typedef enum logic [1:0] {
		src_reg = 2'd0,
		src_imm = 2'd1
	} alu_src_e;

	// fetch to decode
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] instr;
		logic [xlen-1:0] pc_next;
	} fetch_pkt_t;

	typedef struct packed {
		opcode_e  alu_op;
		alu_src_e alu_src;
		logic     branch;
		logic     jump;
		logic     mem_en;
		logic     mem_wrt;
		logic     reg_wrt_en;
		logic     link;
		logic     illegal;
	} ctrl_t;

	// decode to execute
	typedef struct packed {
		logic                 valid;
		ctrl_t                ctrl;
		logic [xlen-1:0]      rs1_data;
		logic [xlen-1:0]      rs2_data;
		logic [xlen-1:0]      imm;
		logic [reg_sel_w-1:0] rd;
		logic [xlen-1:0]      pc_next;
	} exec_pkt_t;

	// register write, also the writeback port
	typedef struct packed {
		logic                 valid;
		logic [reg_sel_w-1:0] sel;
		logic [xlen-1:0]      data;
	} wb_t;

	typedef struct packed {
		logic            valid;
		logic            wrt;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

endpackage

/* src/decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage, builds the execute packet
// holds the register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  fetch_pkt_t fetch_pkt,
	input  wb_t        wb,
	output exec_pkt_t  exec_pkt
);

	opcode_e              opcode;
	ctrl_t                ctrl;
	logic [reg_sel_w-1:0] rs1_sel;
	logic [reg_sel_w-1:0] rs2_sel;
	logic [xlen-1:0]      rs1_data;
	logic [xlen-1:0]      rs2_data;
	logic [xlen-1:0]      imm_short;
	logic [xlen-1:0]      imm_long;
	logic                 use_long;

	// field extraction
	assign opcode  = opcode_e'(fetch_pkt.instr[op_msb:op_lsb]);
	assign rs1_sel = fetch_pkt.instr[rs1_msb:rs1_lsb];
	assign rs2_sel = fetch_pkt.instr[rs2_msb:rs2_lsb];

	// sign extended immediates
	assign imm_short = {{(xlen - imm_s_msb - 1){fetch_pkt.instr[imm_s_msb]}},
		fetch_pkt.instr[imm_s_msb:0]};
	assign imm_long  = {{(xlen - imm_l_msb - 1){fetch_pkt.instr[imm_l_msb]}},
		fetch_pkt.instr[imm_l_msb:0]};
	// only j and jal carry the long form
	assign use_long  = (opcode == op_j) || (opcode == op_jal);

	// register reads, same cycle
	reg_file_bypass reg_file_bypass_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_sel  (rs1_sel),
		.rd2_sel  (rs2_sel),
		.rd1_data (rs1_data),
		.rd2_data (rs2_data),
		.wb       (wb)
	);

	// control decode
	always_comb begin
		ctrl         = '0;
		ctrl.alu_op  = opcode;
		ctrl.alu_src = src_reg;
		case (opcode)
			op_add, op_sub, op_and, op_or, op_xor, op_neg, op_sll, op_slr, op_sar: begin
				ctrl.reg_wrt_en = 1'b1;
			end
			op_addi, op_subi: begin
				ctrl.alu_src    = src_imm;
				ctrl.reg_wrt_en = 1'b1;
			end
			// loads issue a request only
			op_ld: begin
				ctrl.mem_en = 1'b1;
			end
			op_ldi: begin
				ctrl.alu_src = src_imm;
				ctrl.mem_en  = 1'b1;
			end
			op_st: begin
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wrt = 1'b1;
			end
			op_sti: begin
				ctrl.alu_src = src_imm;
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wrt = 1'b1;
			end
			op_nop, op_rin: begin
				// no effect
			end
			op_beq, op_bne, op_bon, op_bnn: begin
				ctrl.branch = 1'b1;
			end
			op_j: begin
				ctrl.alu_src = src_imm;
				ctrl.jump    = 1'b1;
			end
			op_jr: begin
				ctrl.jump = 1'b1;
			end
			op_jal: begin
				ctrl.alu_src    = src_imm;
				ctrl.jump       = 1'b1;
				ctrl.link       = 1'b1;
				ctrl.reg_wrt_en = 1'b1;
			end
			default: begin
				// unknown code retires as a nop with the flag up
				ctrl         = '0;
				ctrl.alu_op  = op_nop;
				ctrl.illegal = 1'b1;
			end
		endcase
	end

	// execute packet
	always_comb begin
		exec_pkt.valid    = fetch_pkt.valid;
		exec_pkt.ctrl     = ctrl;
		exec_pkt.rs1_data = rs1_data;
		exec_pkt.rs2_data = rs2_data;
		exec_pkt.imm      = use_long ? imm_long : imm_short;
		exec_pkt.rd       = fetch_pkt.instr[rd_msb:rd_lsb];
		exec_pkt.pc_next  = fetch_pkt.pc_next;
	end

endmodule

/* src/execute.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage, alu and branch resolution
// drives writeback, memory and redirect
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
	input  exec_pkt_t exec_pkt,
	output wb_t       wb,
	output mem_req_t  mem_req,
	output redirect_t redirect,
	output logic      illegal
);

	ctrl_t           ctrl;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] rel_target;
	logic            taken;

	assign ctrl = exec_pkt.ctrl;
	assign op_a = exec_pkt.rs1_data;
	// second operand, immediate or rs2
	assign op_b = (ctrl.alu_src == src_imm) ? exec_pkt.imm : exec_pkt.rs2_data;

	// alu
	always_comb begin
		case (ctrl.alu_op)
			op_add, op_addi: alu_result = op_a + op_b;
			op_sub, op_subi: alu_result = op_a - op_b;
			op_and:          alu_result = op_a & op_b;
			op_or:           alu_result = op_a | op_b;
			op_xor:          alu_result = op_a ^ op_b;
			op_neg:          alu_result = -op_a;
			// shift amount always from rs2
			op_sll: alu_result = op_a << exec_pkt.rs2_data[shamt_w-1:0];
			op_slr: alu_result = op_a >> exec_pkt.rs2_data[shamt_w-1:0];
			op_sar: alu_result = $signed(op_a) >>> exec_pkt.rs2_data[shamt_w-1:0];
			default:         alu_result = '0;
		endcase
	end

	// branch condition
	always_comb begin
		case (ctrl.alu_op)
			op_beq:  taken = (op_a == exec_pkt.rs2_data);
			op_bne:  taken = (op_a != exec_pkt.rs2_data);
			op_bon:  taken = op_a[xlen-1];
			op_bnn:  taken = !op_a[xlen-1];
			default: taken = 1'b0;
		endcase
	end

	// pc relative target for branches, j and jal
	assign rel_target = exec_pkt.pc_next + exec_pkt.imm;

	// redirect to fetch, also flushes both stage registers
	always_comb begin
		redirect.valid  = exec_pkt.valid && (ctrl.jump || (ctrl.branch && taken));
		redirect.target = (ctrl.alu_op == op_jr) ? op_a : rel_target;
	end

	// writeback, jal links the return address
	always_comb begin
		wb.valid = exec_pkt.valid && ctrl.reg_wrt_en;
		wb.sel   = exec_pkt.rd;
		wb.data  = ctrl.link ? exec_pkt.pc_next : alu_result;
	end

	// memory request
	// address is rs1 plus imm or rs2 through op_b
	always_comb begin
		mem_req.valid = exec_pkt.valid && ctrl.mem_en;
		mem_req.wrt   = ctrl.mem_wrt;
		mem_req.addr  = op_a + op_b;
		mem_req.wdata = exec_pkt.rs2_data;
	end

	// one cycle pulse per illegal instruction
	assign illegal = exec_pkt.valid && ctrl.illegal;

endmodule

/* src/fetch_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter and instruction fetch
// feeds the if_id pipeline register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  redirect_t       redirect,
	output logic [xlen-1:0] imem_addr,
	input  logic [xlen-1:0] imem_data,
	output fetch_pkt_t      fetch_pkt
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;

	// sequential address and pc_next of the packet
	assign pc_plus4 = pc + 32'd4;

	// pc update
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect.valid) begin
			// taken branch or jump from execute
			pc <= redirect.target;
		end else begin
			pc <= pc_plus4;
		end
	end

	// memory answers in the same cycle
	assign imem_addr = pc;

	// packet toward decode
	// valid once out of reset
	always_comb begin
		fetch_pkt.valid   = rst_n;
		fetch_pkt.instr   = imem_data;
		fetch_pkt.pc_next = pc_plus4;
	end

endmodule

/* src/pipe_reg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one pipeline stage register for any packet
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pipe_reg #(
	// packet type, valid must be its leading bit
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// payload always follows d
	// only the valid bit is killed on reset or flush
	always_ff @(posedge clk) begin
		q <= d;
		if (!rst_n || flush) begin
			q[$bits(payload_t)-1] <= 1'b0;
		end
	end

endmodule

/* src/reg_file_bypass.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file with two reads and one write
// reads see a same-cycle write through bypass
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reg_file_bypass import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [reg_sel_w-1:0] rd1_sel,
	input  logic [reg_sel_w-1:0] rd2_sel,
	output logic [xlen-1:0]      rd1_data,
	output logic [xlen-1:0]      rd2_data,
	input  wb_t                  wb
);

	logic [xlen-1:0] regs [num_regs];
	logic            wr_hit;

	// r0 is never written
	assign wr_hit = wb.valid && (wb.sel != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wb.sel] <= wb.data;
		end
	end

	// one read port
	// incoming write data wins over the stored copy
	function automatic logic [xlen-1:0] read_port(input logic [reg_sel_w-1:0] sel);
		logic [xlen-1:0] val;
		if (sel == '0) begin
			val = '0;
		end else if (wr_hit && (wb.sel == sel)) begin
			val = wb.data;
		end else begin
			val = regs[sel];
		end
		return val;
	endfunction

	// reevaluated on any change of the stored or incoming data
	always_comb begin
		rd1_data = read_port(rd1_sel);
		rd2_data = read_port(rd2_sel);
	end

endmodule

/* tests/core_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the core
// runs one program against an instruction level model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module core_tb import cpu_pkg::*; ();

	typedef enum logic [1:0] {
		ev_wb  = 2'd1,
		ev_mem = 2'd2,
		ev_ill = 2'd3
	} ev_kind_e;

	// one expected output event
	// cyc counts edges after reset
	typedef struct packed {
		ev_kind_e    kind;
		logic [31:0] cyc;
		logic [4:0]  sel;
		logic        wrt;
		logic [31:0] a;
		logic [31:0] b;
	} event_t;

	logic            clk;
	logic            rst_n;
	logic [xlen-1:0] imem_addr;
	logic [xlen-1:0] imem_data;
	wb_t             wb;
	mem_req_t        mem_req;
	logic            illegal;

	logic [31:0] imem [256];
	logic [31:0] model_rf [32];
	// expected fetch address per cycle including squashed fetches
	logic [31:0] trace_q [$];
	event_t      ev_q [$];
	event_t      head;
	logic [31:0] exp_pc;
	logic [15:0] lfsr       = 16'd62170;
	int          prog_len   = 0;
	int          trace_len  = 0;
	int          cyc_cnt    = 0;
	int          val_errs   = 0;
	int          misc_errs  = 0;
	logic        model_done = 1'b0;

	core_top core_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb),
		.mem_req   (mem_req),
		.illegal   (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr[9:2]];

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] enc(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
		logic [16:0] imm);
		return {op, rd, rs1, imm};
	endfunction

	task automatic put(logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// branch skipping two sentinel writes when taken
	task automatic branch_case(opcode_e op, logic [4:0] rs1);
		put(enc(op, 5'd0, rs1, 17'd8));
		put(enc(op_addi, 5'd20, 5'd0, 17'h00111));
		put(enc(op_addi, 5'd21, 5'd0, 17'h00222));
	endtask

	task automatic build_program();
		opcode_e    alu_ops [11] = '{op_add, op_addi, op_sub, op_subi, op_and, op_or,
			op_xor, op_neg, op_sll, op_slr, op_sar};
		opcode_e    op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] last_rd;
		logic [11:0] low;
		// nop fill with the word address in the low bits
		for (int i = 0; i < 256; i++) begin
			imem[i] = {op_nop, 27'(i)};
		end
		// random operands into r1 to r7
		for (int r = 1; r < 8; r++) begin
			put(enc(op_addi, 5'(r), 5'd0, 17'(rand_bits(17))));
		end
		last_rd = 5'd7;
		// each alu op in turn on random registers
		// every other one reads the previous result
		for (int k = 0; k < 24; k++) begin
			op  = alu_ops[k % 11];
			rd  = 5'(rand_bits(3) + 1);
			rs1 = 5'(rand_bits(3) + 1);
			if (k % 2 == 1) begin
				rs1 = last_rd;
			end
			rs2 = 5'(rand_bits(3) + 1);
			low = 12'(rand_bits(12));
			put({op, rd, rs1, rs2, low});
			last_rd = rd;
		end
		// r8 negative, r9 positive, r10 zero
		put(enc(op_addi, 5'd8, 5'd0, -17'sd5));
		put(enc(op_addi, 5'd9, 5'd0, 17'd7));
		put(enc(op_sub, 5'd10, 5'd9, {5'd9, 12'd0}));
		// rs2 field is r0 so the offset stays small
		branch_case(op_beq, 5'd10);
		branch_case(op_beq, 5'd8);
		branch_case(op_bne, 5'd8);
		branch_case(op_bne, 5'd10);
		branch_case(op_bon, 5'd8);
		branch_case(op_bon, 5'd9);
		branch_case(op_bnn, 5'd9);
		branch_case(op_bnn, 5'd8);
		branch_case(op_j, 5'd0);
		// jal into the body
		// the j skips the body after the return
		put(enc(op_jal, 5'd11, 5'd0, 17'd4));
		put(enc(op_j, 5'd0, 5'd0, 17'd8));
		put(enc(op_xor, 5'd12, 5'd11, {5'd1, 12'd0}));
		put(enc(op_jr, 5'd0, 5'd11, 17'd0));
		put(enc(op_ld, 5'd0, 5'd1, {5'd2, 12'd0}));
		put(enc(op_ldi, 5'd0, 5'd3, 17'(rand_bits(17))));
		put(enc(op_st, 5'd0, 5'd4, {5'd5, 12'd0}));
		put(enc(op_sti, 5'd0, 5'd6, 17'(rand_bits(17))));
		// two undefined codes and rin before one more write
		put({5'd23, 27'(rand_bits(27))});
		put({5'd30, 27'(rand_bits(27))});
		put({op_rin, 27'd0});
		put(enc(op_addi, 5'd22, 5'd0, 17'h00abc));
	endtask

	// event tied to the fetch just pushed
	// seen two edges later
	function automatic void add_event(ev_kind_e kind, logic [4:0] sel, logic wrt,
		logic [31:0] a, logic [31:0] b);
		event_t e;
		e.kind = kind;
		e.cyc  = 32'(trace_q.size() + 1);
		e.sel  = sel;
		e.wrt  = wrt;
		e.a    = a;
		e.b    = b;
		ev_q.push_back(e);
	endfunction

	function automatic void write_reg(logic [4:0] rd, logic [31:0] val);
		add_event(ev_wb, rd, 1'b0, val, 32'd0);
		if (rd != 5'd0) begin
			model_rf[rd] = val;
		end
	endfunction

	// in order model of the program
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		logic [31:0] imm_l;
		logic [31:0] tgt;
		logic [4:0]  rd;
		logic        taken;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			model_rf[i] = '0;
		end
		pc    = '0;
		steps = 0;
		while (pc < 32'(4 * prog_len) && steps < 500) begin
			ins   = imem[pc[9:2]];
			a     = model_rf[ins[21:17]];
			b     = model_rf[ins[16:12]];
			rd    = ins[26:22];
			imm_s = {{15{ins[16]}}, ins[16:0]};
			imm_l = {{10{ins[21]}}, ins[21:0]};
			taken = 1'b0;
			tgt   = pc + 32'd4 + imm_s;
			trace_q.push_back(pc);
			case (ins[31:27])
				op_add:  write_reg(rd, a + b);
				op_addi: write_reg(rd, a + imm_s);
				op_sub:  write_reg(rd, a - b);
				op_subi: write_reg(rd, a - imm_s);
				op_and:  write_reg(rd, a & b);
				op_or:   write_reg(rd, a | b);
				op_xor:  write_reg(rd, a ^ b);
				op_neg:  write_reg(rd, -a);
				op_sll:  write_reg(rd, a << b[4:0]);
				op_slr:  write_reg(rd, a >> b[4:0]);
				op_sar:  write_reg(rd, $signed(a) >>> b[4:0]);
				op_ld:   add_event(ev_mem, 5'd0, 1'b0, a + b, b);
				op_ldi:  add_event(ev_mem, 5'd0, 1'b0, a + imm_s, b);
				op_st:   add_event(ev_mem, 5'd0, 1'b1, a + b, b);
				op_sti:  add_event(ev_mem, 5'd0, 1'b1, a + imm_s, b);
				op_nop, op_rin: begin
					// retire with no effect
				end
				op_beq:  taken = (a == b);
				op_bne:  taken = (a != b);
				op_bon:  taken = a[31];
				op_bnn:  taken = !a[31];
				op_j: begin
					taken = 1'b1;
					tgt   = pc + 32'd4 + imm_l;
				end
				op_jr: begin
					taken = 1'b1;
					tgt   = a;
				end
				op_jal: begin
					write_reg(rd, pc + 32'd4);
					taken = 1'b1;
					tgt   = pc + 32'd4 + imm_l;
				end
				default: add_event(ev_ill, 5'd0, 1'b0, 32'd0, 32'd0);
			endcase
			if (taken) begin
				// two younger fetches get squashed
				trace_q.push_back(pc + 32'd4);
				trace_q.push_back(pc + 32'd8);
				pc = tgt;
			end else begin
				pc = pc + 32'd4;
			end
			steps++;
		end
	endtask

	task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			val_errs++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_event(event_t e);
		check_val("event cycle", e.cyc, cyc_cnt);
		check_val("wb.valid", e.kind == ev_wb, wb.valid);
		check_val("mem_req.valid", e.kind == ev_mem, mem_req.valid);
		check_val("illegal", e.kind == ev_ill, illegal);
		if (e.kind == ev_wb) begin
			check_val("wb.sel", e.sel, wb.sel);
			check_val("wb.data", e.a, wb.data);
		end
		if (e.kind == ev_mem) begin
			check_val("mem_req.wrt", e.wrt, mem_req.wrt);
			check_val("mem_req.addr", e.a, mem_req.addr);
			// load data field carries no meaning
			if (e.wrt) begin
				check_val("mem_req.wdata", e.b, mem_req.wdata);
			end
		end
	endtask

	// sampled before the edge moves the pipeline
	always @(posedge clk) begin
		if (rst_n) begin
			if (trace_q.size() > 0) begin
				exp_pc = trace_q.pop_front();
				check_val("imem_addr", exp_pc, imem_addr);
			end
			if (wb.valid || mem_req.valid || illegal) begin
				assert (ev_q.size() > 0) else begin
					misc_errs++;
					$display("output event in cycle %0d with nothing left to retire", cyc_cnt);
				end
				if (ev_q.size() > 0) begin
					head = ev_q.pop_front();
					check_event(head);
				end
			end else if (ev_q.size() > 0) begin
				assert (ev_q[0].cyc > cyc_cnt) else begin
					misc_errs++;
					$display("no output in cycle %0d where an instruction retires", cyc_cnt);
					head = ev_q.pop_front();
				end
			end
			cyc_cnt++;
		end
	end

	initial begin
		rst_n = 1'b0;
		build_program();
		run_model();
		trace_len  = trace_q.size();
		model_done = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// run until every fetch and event is matched
		while (trace_q.size() > 0 || ev_q.size() > 0) begin
			@(negedge clk);
		end
		// catch stray outputs from the fill region
		repeat (2) @(negedge clk);
		$display("value errors %0d, other errors %0d", val_errs, misc_errs);
		if (val_errs == 0 && misc_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog over run length plus reset plus margin
	initial begin
		wait (model_done);
		repeat (trace_len + 50 + 8) @(posedge clk);
		$display("timeout, the pipeline did not retire the program in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
